//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_input_queue
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- design/fdam_conf_receiver.sv
`timescale 1ns/10ps

module fdam_conf_receiver #(
  parameter int QUEUE_ID = 3
) (
  input  logic                 clk,
  input  logic                 rst_internal,
  input  fdam_pkg::conf_type_t conf_valid,
  input  fdam_pkg::conf_word_t conf,
  output logic                 conf_ready,
  output fdam_pkg::addr_t      base_addr,
  output fdam_pkg::qtd_t       line_qtd,
  output logic                 queue_clear
);

  import fdam_pkg::*;

  logic [CONF_ID_WIDTH-1:0] conf_id;
  logic                     id_match;
  logic                     take_input;
  logic                     take_clear;

  // Queue id sits in the low bits of the word
  assign conf_id    = conf[CONF_ID_WIDTH-1:0];
  assign id_match   = (conf_id == CONF_ID_WIDTH'(QUEUE_ID));
  assign take_input = id_match && (conf_valid == CONF_INPUT);
  assign take_clear = id_match && (conf_valid == CONF_CLEAR);

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      conf_ready  <= 1'b0;
      queue_clear <= 1'b0;
    end else begin
      queue_clear <= take_clear;
      // A fresh input word wins over a clear still in progress
      if (take_input) begin
        conf_ready <= 1'b1;
      end else if (queue_clear) begin
        conf_ready <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_input) begin
      base_addr <= conf[CONF_WIDTH-1 -: ADDR_WIDTH];
      line_qtd  <= conf[CONF_ID_WIDTH +: QTD_WIDTH];
    end
  end

endmodule

//--- design/fdam_input_queue_controller.sv
`timescale 1ns/10ps

module fdam_input_queue_controller #(
  parameter int QUEUE_ID        = 3,
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic                clk,
  input  logic                rst_internal,
  input  logic                start,
  input  logic                conf_ready,
  input  fdam_pkg::addr_t     base_addr,
  input  fdam_pkg::qtd_t      line_qtd,
  input  logic                queue_clear,
  input  logic                available_read,
  output logic                request_read,
  output fdam_pkg::req_data_t request_data,
  input  logic                read_data_valid,
  input  fdam_pkg::tag_t      read_tag,
  input  fdam_pkg::line_t     read_data,
  output logic                has_rd_pending,
  fdam_queue_if.producer      q
);

  import fdam_pkg::*;

  localparam int CW = FIFO_DEPTH_BITS + 1;
  localparam logic [CW:0] ADMIT_MAX = (CW+1)'((1 << FIFO_DEPTH_BITS) - LINES_PER_REQ);
  localparam tag_t MY_TAG = tag_t'(QUEUE_ID);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DONE_REQ
  } state_t;

  state_t             state;
  addr_t              next_addr;
  qtd_t               req_lines;
  logic [QTD_WIDTH:0] req_lines_next;
  logic [CW-1:0]      outstanding;
  logic [CW:0]        discard;
  logic [CW:0]        committed;
  logic               resp_match;
  logic               resp_keep;
  logic               issue;

  // ==============================
  // Request side
  // ==============================

  assign req_lines_next = {1'b0, req_lines} + (QTD_WIDTH+1)'(LINES_PER_REQ);

  // Lines holding a FIFO slot: in flight, in the write stage, or stored
  assign committed = {1'b0, outstanding} + (CW+1)'(q.wr_en) + {1'b0, q.count};

  assign issue = (state == ISSUE) && start && conf_ready && !queue_clear &&
                 !request_read && available_read && (committed <= ADMIT_MAX);

  always_ff @(posedge clk) begin
    if (rst_internal || queue_clear) begin
      state        <= IDLE;
      req_lines    <= '0;
      request_read <= 1'b0;
    end else begin
      request_read <= issue;
      case (state)
        IDLE: begin
          if (start && conf_ready) begin
            req_lines <= '0;
            state     <= (line_qtd == '0) ? DONE_REQ : ISSUE;
          end
        end
        ISSUE: begin
          if (issue) begin
            req_lines <= req_lines_next[QTD_WIDTH-1:0];
            if (req_lines_next >= {1'b0, line_qtd}) begin
              state <= DONE_REQ;
            end
          end
        end
        default: begin
          state <= DONE_REQ;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      next_addr <= base_addr;
    end else if (issue) begin
      next_addr <= next_addr + addr_t'(LINES_PER_REQ);
    end
    if (issue) begin
      request_data <= {next_addr, MY_TAG};
    end
  end

  // ==============================
  // Response side
  // ==============================

  assign resp_match = read_data_valid && (read_tag == MY_TAG);
  // Responses to requests from before a clear are dropped first
  assign resp_keep  = resp_match && (discard == '0);

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      outstanding <= '0;
      discard     <= '0;
    end else if (queue_clear) begin
      outstanding <= '0;
      discard     <= discard + {1'b0, outstanding} - (CW+1)'(resp_match);
    end else begin
      outstanding <= outstanding + (issue ? CW'(LINES_PER_REQ) : '0) - CW'(resp_keep);
      if (resp_match && (discard != '0)) begin
        discard <= discard - 1'b1;
      end
    end
  end

  assign has_rd_pending = (outstanding != '0);

  always_ff @(posedge clk) begin
    if (rst_internal || queue_clear) begin
      q.wr_en <= 1'b0;
    end else begin
      q.wr_en <= resp_keep;
    end
  end

  always_ff @(posedge clk) begin
    q.wr_data <= read_data;
  end

  // Receiver must hold a valid configuration while requests go out
  a_req_configured: assert property (@(posedge clk) disable iff (rst_internal)
    request_read |-> conf_ready);

endmodule

//--- design/fdam_input_queue_top.sv
`timescale 1ns/10ps

module fdam_input_queue_top #(
  parameter int QUEUE_ID        = 3,
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic                 clk,
  input  logic                 rst_internal,
  input  logic                 start,
  input  fdam_pkg::conf_type_t conf_valid,
  input  fdam_pkg::conf_word_t conf,
  input  logic                 available_read,
  output logic                 request_read,
  output fdam_pkg::req_data_t  request_data,
  input  logic                 read_data_valid,
  input  fdam_pkg::tag_t       read_tag,
  input  fdam_pkg::line_t      read_data,
  output logic                 has_rd_pending,
  output logic                 user_available_read,
  input  logic                 user_request_read,
  output fdam_pkg::line_t      user_read_data,
  output logic                 user_read_data_valid,
  output logic                 done
);

  import fdam_pkg::*;

  logic  conf_ready;
  addr_t base_addr;
  qtd_t  line_qtd;
  logic  queue_clear;

  fdam_queue_if #(.FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)) queue_if ();

  fdam_conf_receiver #(
    .QUEUE_ID(QUEUE_ID)
  ) u_conf_receiver (
    .clk          (clk),
    .rst_internal (rst_internal),
    .conf_valid   (conf_valid),
    .conf         (conf),
    .conf_ready   (conf_ready),
    .base_addr    (base_addr),
    .line_qtd     (line_qtd),
    .queue_clear  (queue_clear)
  );

  fdam_input_queue_controller #(
    .QUEUE_ID        (QUEUE_ID),
    .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
  ) u_controller (
    .clk             (clk),
    .rst_internal    (rst_internal),
    .start           (start),
    .conf_ready      (conf_ready),
    .base_addr       (base_addr),
    .line_qtd        (line_qtd),
    .queue_clear     (queue_clear),
    .available_read  (available_read),
    .request_read    (request_read),
    .request_data    (request_data),
    .read_data_valid (read_data_valid),
    .read_tag        (read_tag),
    .read_data       (read_data),
    .has_rd_pending  (has_rd_pending),
    .q               (queue_if.producer)
  );

  fdam_queue_fifo #(
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) u_fifo (
    .clk          (clk),
    .rst_internal (rst_internal),
    .flush        (queue_clear),
    .q            (queue_if.buffer)
  );

  fdam_queue_reader u_reader (
    .clk                  (clk),
    .rst_internal         (rst_internal),
    .start                (start),
    .line_qtd             (line_qtd),
    .conf_ready           (conf_ready),
    .queue_clear          (queue_clear),
    .user_request_read    (user_request_read),
    .user_available_read  (user_available_read),
    .user_read_data       (user_read_data),
    .user_read_data_valid (user_read_data_valid),
    .done                 (done),
    .q                    (queue_if.consumer)
  );

endmodule

//--- design/fdam_pkg.sv
package fdam_pkg;

  // Bus widths of the scaled design
  localparam int ADDR_WIDTH    = 32;
  localparam int QTD_WIDTH     = 16;
  localparam int DATA_WIDTH    = 32;
  localparam int TAG_WIDTH     = 8;
  localparam int CONF_ID_WIDTH = 8;
  localparam int CONF_WIDTH    = ADDR_WIDTH + QTD_WIDTH + CONF_ID_WIDTH;
  localparam int REQ_WIDTH     = ADDR_WIDTH + TAG_WIDTH;

  // Lines fetched by one memory read request
  localparam int LINES_PER_REQ = 4;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [QTD_WIDTH-1:0]  qtd_t;
  typedef logic [DATA_WIDTH-1:0] line_t;
  typedef logic [TAG_WIDTH-1:0]  tag_t;

  // Configuration word is {address, count, queue id}
  typedef logic [CONF_WIDTH-1:0] conf_word_t;

  // Request word is {address, tag}
  typedef logic [REQ_WIDTH-1:0] req_data_t;

  typedef logic [1:0] conf_type_t;

  localparam conf_type_t CONF_NONE  = 2'd0;
  localparam conf_type_t CONF_INPUT = 2'd1;
  localparam conf_type_t CONF_CLEAR = 2'd2;

endpackage

//--- design/fdam_queue_fifo.sv
`timescale 1ns/10ps

module fdam_queue_fifo #(
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic         clk,
  input  logic         rst_internal,
  input  logic         flush,
  fdam_queue_if.buffer q
);

  import fdam_pkg::*;

  localparam int DEPTH = 1 << FIFO_DEPTH_BITS;

  line_t                      mem [DEPTH];
  logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic [FIFO_DEPTH_BITS:0]   count;

  assign q.count = count;
  assign q.empty = (count == '0);
  assign q.full  = (count == (FIFO_DEPTH_BITS+1)'(DEPTH));

  // ==============================
  // Pointers and occupancy
  // ==============================

  always_ff @(posedge clk) begin
    if (rst_internal || flush) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      q.rd_valid <= 1'b0;
    end else begin
      if (q.wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (q.rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count      <= count + (FIFO_DEPTH_BITS+1)'(q.wr_en) - (FIFO_DEPTH_BITS+1)'(q.rd_en);
      q.rd_valid <= q.rd_en;
    end
  end

  // ==============================
  // Storage
  // ==============================

  always_ff @(posedge clk) begin
    if (q.wr_en) begin
      mem[wr_ptr] <= q.wr_data;
    end
  end

  // Read data lands one cycle after rd_en
  always_ff @(posedge clk) begin
    if (q.rd_en) begin
      q.rd_data <= mem[rd_ptr];
    end
  end

  // Producer admission and consumer gating keep both ends in bounds
  a_no_overflow: assert property (@(posedge clk) disable iff (rst_internal)
    q.wr_en |-> !q.full);
  a_no_underflow: assert property (@(posedge clk) disable iff (rst_internal)
    q.rd_en |-> !q.empty);

endmodule

//--- design/fdam_queue_if.sv
`timescale 1ns/10ps

interface fdam_queue_if #(
  parameter int FIFO_DEPTH_BITS = 4
);

  import fdam_pkg::*;

  // Write side
  logic                     wr_en;
  line_t                    wr_data;

  // Read side
  logic                     rd_en;
  line_t                    rd_data;
  logic                     rd_valid;

  // Status
  logic [FIFO_DEPTH_BITS:0] count;
  logic                     empty;
  logic                     full;

  modport producer (output wr_en, wr_data, input count);
  modport buffer (input wr_en, wr_data, rd_en, output rd_data, rd_valid, count, empty, full);
  modport consumer (output rd_en, input rd_data, rd_valid, count, empty);

endinterface

//--- design/fdam_queue_reader.sv
`timescale 1ns/10ps

module fdam_queue_reader (
  input  logic             clk,
  input  logic             rst_internal,
  input  logic             start,
  input  fdam_pkg::qtd_t   line_qtd,
  input  logic             conf_ready,
  input  logic             queue_clear,
  input  logic             user_request_read,
  output logic             user_available_read,
  output fdam_pkg::line_t  user_read_data,
  output logic             user_read_data_valid,
  output logic             done,
  fdam_queue_if.consumer   q
);

  import fdam_pkg::*;

  qtd_t delivered;
  logic last_line;

  assign q.rd_en = user_request_read;

  // True for a count of zero or one
  assign last_line = ((q.count >> 1) == '0);

  always_ff @(posedge clk) begin
    if (rst_internal || queue_clear) begin
      user_available_read  <= 1'b0;
      user_read_data_valid <= 1'b0;
      delivered            <= '0;
      done                 <= 1'b0;
    end else begin
      // Offer a line only if one is left after this cycle's read
      user_available_read  <= !q.empty && !(q.rd_en && last_line);
      user_read_data_valid <= q.rd_valid;
      if (q.rd_valid) begin
        delivered <= delivered + 1'b1;
      end
      done <= start && conf_ready && (delivered >= line_qtd);
    end
  end

  always_ff @(posedge clk) begin
    user_read_data <= q.rd_data;
  end

endmodule

//--- dv/tb_input_queue.sv
`timescale 1ns/10ps

module tb_input_queue;

  import fdam_pkg::*;

  localparam int    QUEUE_ID        = 3;
  localparam int    FIFO_DEPTH_BITS = 4;
  localparam int    ROOM            = (1 << FIFO_DEPTH_BITS) - LINES_PER_REQ;
  localparam int    LIMIT           = 4000;
  localparam line_t DATA_KEY        = 32'h5a5a_0000;

  logic       clk;
  logic       rst_internal;
  logic       start;
  conf_type_t conf_valid;
  conf_word_t conf;
  logic       available_read, request_read, read_data_valid, has_rd_pending;
  req_data_t  request_data;
  tag_t       read_tag;
  line_t      read_data, user_read_data;
  logic       user_available_read, user_request_read, user_read_data_valid, done;

  // Running totals, taken per transfer relative to the *_base marks
  string      test_name;
  addr_t      cur_base;
  int         cur_lines, seen_base, req_base, read_base, err_mark;
  int         seen = 0;
  int         reqs = 0;
  int         reads = 0;
  int         errors = 0;
  int         tests = 0;
  int         failed = 0;
  logic [1:0] read_hist = '0;
  logic       in_reset = 1'b1;
  line_t      want;

  fdam_input_queue_top #(
    .QUEUE_ID        (QUEUE_ID),
    .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
  ) DUT (.*);

  tb_mem_model #(.QUEUE_ID(QUEUE_ID)) mem (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==============================
  // Monitors
  // ==============================

  always @(posedge clk) begin
    in_reset  <= rst_internal;
    read_hist <= {read_hist[0], user_request_read};
    reads     <= reads + (user_request_read ? 1 : 0);
  end

  always @(negedge clk) begin
    if (!in_reset) begin
      assert (user_read_data_valid == read_hist[1]) else begin
        errors++;
        $display("ERR %s valid delay: expected %0b, actual %0b", test_name, read_hist[1],
                 user_read_data_valid);
      end
      if (user_read_data_valid) begin
        want = (cur_base + addr_t'(seen - seen_base)) ^ DATA_KEY;
        assert (user_read_data == want) else begin
          errors++;
          $display("ERR %s line %0d: expected %h, actual %h", test_name, seen - seen_base,
                   want, user_read_data);
        end
        seen <= seen + 1;
      end
      if (request_read) begin
        assert (request_data == {cur_base + addr_t'(reqs - req_base), tag_t'(QUEUE_ID)}) else begin
          errors++;
          $display("ERR %s request: expected %h, actual %h", test_name,
                   {cur_base + addr_t'(reqs - req_base), tag_t'(QUEUE_ID)}, request_data);
        end
        assert ((reqs - req_base < cur_lines) && (reqs - req_base - (reads - read_base) <= ROOM))
        else begin
          errors++;
          $display("%s: request issued past the line count or without FIFO room", test_name);
        end
        reqs <= reqs + LINES_PER_REQ;
      end
      assert (!done || (seen - seen_base >= cur_lines)) else begin
        errors++;
        $display("%s: done raised before all lines were delivered", test_name);
      end
    end
  end

  // ==============================
  // Stimulus tasks
  // ==============================

  task automatic send_conf(conf_type_t kind, addr_t addr, int lines, int id);
    @(negedge clk);
    conf_valid = kind;
    conf       = {addr, qtd_t'(lines), CONF_ID_WIDTH'(id)};
    @(negedge clk);
    conf_valid = CONF_NONE;
  endtask

  task automatic start_test(string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic report_test();
    tests++;
    if (errors != err_mark) begin
      failed++;
      $display("test %s: %0d errors", test_name, errors - err_mark);
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  // Flush whatever came before, then configure a fresh transfer
  task automatic begin_transfer(addr_t base, int lines);
    start = 1'b0;
    send_conf(CONF_CLEAR, '0, 0, QUEUE_ID);
    repeat (2) @(negedge clk);
    cur_base  = base;
    cur_lines = lines;
    seen_base = seen;
    req_base  = reqs;
    read_base = reads;
    send_conf(CONF_INPUT, base, lines, QUEUE_ID);
    start = 1'b1;
  endtask

  task automatic read_lines(int n, int gap, int stall);
    int issued;
    int idle;
    issued = 0;
    idle   = 0;
    while (issued < n && idle < LIMIT) begin
      @(negedge clk);
      user_request_read = 1'b0;
      if (int'($urandom_range(99, 0)) < stall) begin
        repeat ($urandom_range(60, 20)) @(negedge clk);
      end
      if (user_available_read && $urandom_range(gap, 0) == 0) begin
        user_request_read = 1'b1;
        issued++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    @(negedge clk);
    user_request_read = 1'b0;
    if (issued < n) begin
      errors++;
      $display("%s: timed out after %0d of %0d user reads", test_name, issued, n);
    end
  endtask

  function automatic logic reached(int sel);
    case (sel)
      0:       return (seen - seen_base) >= cur_lines;
      1:       return done;
      default: return !has_rd_pending;
    endcase
  endfunction

  task automatic wait_for(int sel, string what);
    int waited;
    waited = 0;
    while (!reached(sel) && waited < LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!reached(sel)) begin
      errors++;
      $display("%s: timed out waiting for %s", test_name, what);
    end
  endtask

  task automatic finish_transfer();
    int want_reqs;
    want_reqs = ((cur_lines + LINES_PER_REQ - 1) / LINES_PER_REQ) * LINES_PER_REQ;
    wait_for(0, "all user lines");
    wait_for(1, "done");
    wait_for(2, "pending reads to drain");
    assert (reqs - req_base == want_reqs) else begin
      errors++;
      $display("ERR %s requested lines: expected %0d, actual %0d", test_name, want_reqs,
               reqs - req_base);
    end
  endtask

  task automatic run_transfer(string name, addr_t base, int lines, int gap, int stall);
    start_test(name);
    begin_transfer(base, lines);
    read_lines(lines, gap, stall);
    finish_transfer();
    report_test();
  endtask

  // ==============================
  // Test sequence
  // ==============================

  initial begin
    void'($urandom(32'hca37_8a35));
    rst_internal      = 1'b1;
    start             = 1'b0;
    conf_valid        = CONF_NONE;
    conf              = '0;
    user_request_read = 1'b0;
    repeat (16) @(negedge clk);
    rst_internal = 1'b0;
    @(negedge clk);
    start_test("reset");
    assert (!request_read && !user_read_data_valid && !done && !has_rd_pending &&
            !user_available_read) else begin
      errors++;
      $display("%s: an output is high after reset", test_name);
    end
    report_test();

    run_transfer("data_order", 32'h0000_1000, 24, 1, 0);

    start_test("foreign");
    begin_transfer(32'h0002_0040, 13);
    fork
      read_lines(13, 1, 0);
      begin
        repeat (20) @(negedge clk);
        send_conf(CONF_INPUT, 32'h0bad_0000, 99, QUEUE_ID + 1);
        send_conf(CONF_CLEAR, '0, 0, QUEUE_ID + 2);
      end
    join
    finish_transfer();
    report_test();

    run_transfer("back_pressure", 32'h0100_0000, 48, 0, 6);
    run_transfer("completion", 32'h00ab_cd00, 6, 0, 0);

    // Clear in the middle of a long transfer, then start over
    start_test("clear");
    begin_transfer(32'h0000_8000, 64);
    read_lines(10, 1, 0);
    repeat (3) @(negedge clk);
    send_conf(CONF_CLEAR, '0, 0, QUEUE_ID);
    @(negedge clk);
    assert (!done && !user_available_read && !has_rd_pending) else begin
      errors++;
      $display("%s: done, user_available_read or has_rd_pending high after clear", test_name);
    end
    begin_transfer(32'h0000_3000, 20);
    read_lines(20, 2, 0);
    finish_transfer();
    report_test();

    $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- dv/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model #(
  parameter int QUEUE_ID = 3
) (
  input  logic                clk,
  input  logic                request_read,
  input  fdam_pkg::req_data_t request_data,
  output logic                available_read,
  output logic                read_data_valid,
  output fdam_pkg::tag_t      read_tag,
  output fdam_pkg::line_t     read_data
);

  import fdam_pkg::*;

  localparam line_t DATA_KEY = 32'h5a5a_0000;

  addr_t req_addr [$];
  tag_t  req_tag [$];
  int    req_due [$];
  int    cycle;
  int    beat;

  // Requests are served in arrival order, one line per cycle
  initial begin
    available_read  = 1'b0;
    read_data_valid = 1'b0;
    read_tag        = '0;
    read_data       = '0;
    cycle           = 0;
    beat            = 0;
    forever begin
      @(negedge clk);
      cycle++;
      read_data_valid = 1'b0;
      if (request_read) begin
        req_addr.push_back(request_data[REQ_WIDTH-1 -: ADDR_WIDTH]);
        req_tag.push_back(request_data[TAG_WIDTH-1:0]);
        req_due.push_back(cycle + int'($urandom_range(12, 1)));
      end
      available_read = ($urandom_range(7, 0) != 0);
      if ($urandom_range(19, 0) == 0) begin
        // Line meant for some other queue
        read_data_valid = 1'b1;
        read_tag        = tag_t'(QUEUE_ID + 1 + int'($urandom_range(200, 0)));
        read_data       = $urandom();
      end else if (req_addr.size() != 0 && cycle >= req_due[0]) begin
        read_data_valid = 1'b1;
        read_tag        = req_tag[0];
        read_data       = (req_addr[0] + addr_t'(beat)) ^ DATA_KEY;
        beat++;
        if (beat == LINES_PER_REQ) begin
          beat = 0;
          void'(req_addr.pop_front());
          void'(req_tag.pop_front());
          void'(req_due.pop_front());
        end
      end
    end
  end

endmodule

//--- verilog.f
design/fdam_pkg.sv
design/fdam_queue_if.sv
design/fdam_conf_receiver.sv
design/fdam_input_queue_controller.sv
design/fdam_queue_fifo.sv
design/fdam_queue_reader.sv
design/fdam_input_queue_top.sv
dv/tb_mem_model.sv
dv/tb_input_queue.sv
